// File: Makefile
VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= test passed

.PHONY: sim clean

# build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: rtl/lsu_aw_issue.sv
`timescale 1ns/1ps

module lsu_aw_issue (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         awrdy,
    lsu_store_if.dram_eng                st,
    output logic                         awvld,
    output logic [lsu_pkg::AW_ADDR_W-1:0] awaddr,
    output logic [7:0]                   awlen,
    output logic [2:0]                   awsize,
    output logic [2:0]                   awstr,
    output logic [4:0]                   awnum
);
    import lsu_pkg::*;

    logic                 pending;
    logic [AW_ADDR_W-1:0] addr_q;
    logic [7:0]           len_q;
    logic [2:0]           size_q;
    logic [2:0]           str_q;
    logic [4:0]           num_q;
    logic [4:0]           num_raw;

    // 16 words per row, fewer as the element size grows
    assign num_raw = 5'b10000 >> st.cmd.len;

    // request stays up under back-pressure
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else begin
            pending <= (st.dram_start | pending) & ~awrdy;
        end
    end

    // captured once, held through every stall cycle
    always_ff @(posedge clk) begin
        if (st.dram_start) begin
            addr_q <= st.cmd.dram_addr[13:4];
            len_q  <= st.cmd.num;
            size_q <= st.cmd.len;
            str_q  <= st.cmd.str;
            num_q  <= num_raw;
        end
    end

    assign awvld      = st.dram_start | pending;
    assign st.aw_done = awvld & awrdy;

    // start cycle reads the command directly, later cycles the registers
    assign awaddr = st.dram_start ? st.cmd.dram_addr[13:4] : addr_q;
    assign awlen  = st.dram_start ? st.cmd.num : len_q;
    assign awsize = st.dram_start ? st.cmd.len : size_q;
    assign awstr  = st.dram_start ? st.cmd.str : str_q;
    assign awnum  = st.dram_start ? num_raw : num_q;

endmodule

// File: rtl/lsu_ctrl.sv
`timescale 1ns/1ps

module lsu_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                instr_vld,
    input  logic                st_iram,
    input  logic                st_wram,
    input  logic                st_oram,
    input  logic                st_dram,
    input  lsu_pkg::store_cmd_t cmd_in,
    output logic                rdy,
    lsu_store_if.ctrl           st
);
    import lsu_pkg::*;

    logic        busy;
    logic        any_st;
    logic        finish;
    logic        accept;
    store_kind_e kind_dec;

    assign any_st = st_iram | st_wram | st_oram | st_dram;
    assign finish = st.sram_done | st.aw_done;

    // reopen in the finish cycle so the next store can go back to back
    assign rdy    = ~busy | finish;
    assign accept = instr_vld & rdy & any_st;

    // iram first, dram last
    assign kind_dec = st_iram ? STORE_IRAM :
                      st_wram ? STORE_WRAM :
                      st_oram ? STORE_ORAM : STORE_DRAM;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (finish) begin
            busy <= 1'b0;
        end
    end

    // kick the matching engine in the cycle after acceptance
    always_ff @(posedge clk) begin
        if (rst) begin
            st.sram_start <= 1'b0;
            st.dram_start <= 1'b0;
        end else begin
            st.sram_start <= accept & (kind_dec != STORE_DRAM);
            st.dram_start <= accept & (kind_dec == STORE_DRAM);
        end
    end

    // command stays put until the next accept edge
    always_ff @(posedge clk) begin
        if (accept) begin
            st.cmd      <= cmd_in;
            st.cmd.kind <= kind_dec;
        end
    end

endmodule

// File: rtl/lsu_pkg.sv
package lsu_pkg;

    // result array geometry, int8 rows only
    localparam int ROW_NUM  = 16;
    localparam int ROW_BITS = 128;

    // buffer row address and AXI word address
    localparam int SRAM_ADDR_W = 8;
    localparam int AW_ADDR_W   = 10;

    // encoding follows the old store type field, dram is all ones
    typedef enum logic [1:0] {
        STORE_IRAM = 2'b00,
        STORE_WRAM = 2'b01,
        STORE_ORAM = 2'b10,
        STORE_DRAM = 2'b11
    } store_kind_e;

    // one int8 result row, also the shape of write data and write mask
    typedef logic [ROW_BITS-1:0] row_data_t;

    // whole result array as seen from the matrix unit
    typedef row_data_t [ROW_NUM-1:0] row_array_t;

    typedef logic [$clog2(ROW_NUM)-1:0] row_idx_t;
    typedef logic [SRAM_ADDR_W-1:0] sram_addr_t;

    // accepted store instruction, held for the whole store
    typedef struct packed {
        store_kind_e kind;
        logic [30:0] dram_addr;
        logic [7:0]  num;
        logic [2:0]  len;
        logic [2:0]  str;
        logic [3:0]  start_x;
        row_idx_t    start_y;
        // ld_st_addr[11:4]
        sram_addr_t  sram_addr;
    } store_cmd_t;

endpackage

// File: rtl/lsu_row_store.sv
`timescale 1ns/1ps

module lsu_row_store (
    input  logic                 clk,
    input  logic                 rst,
    input  lsu_pkg::row_array_t  rows,
    input  logic                 data_rdy,
    lsu_store_if.sram_eng        st,
    output logic                 we,
    output lsu_pkg::store_kind_e bank,
    output lsu_pkg::sram_addr_t  addr,
    output lsu_pkg::row_data_t   wmask,
    output lsu_pkg::row_data_t   din
);
    import lsu_pkg::*;

    logic       waiting;
    logic       running;
    logic       first;
    logic       last;
    row_idx_t   k_q;
    row_idx_t   k_cur;
    sram_addr_t addr_q;
    sram_addr_t addr_cur;
    row_idx_t   row_sel;
    logic [7:0] win_w;
    logic [6:0] win_lo;
    row_data_t  win;

    // first write may land in the start cycle itself
    assign first = (st.sram_start | waiting) & data_rdy;
    assign we    = first | running;

    // counters are not loaded yet in the start cycle
    assign k_cur    = st.sram_start ? '0 : k_q;
    assign addr_cur = st.sram_start ? st.cmd.sram_addr : addr_q;

    assign last         = we & ({4'b0, k_cur} == st.cmd.num - 8'd1);
    assign st.sram_done = last;

    // wait for the result array, sampled only once per store
    always_ff @(posedge clk) begin
        if (rst) begin
            waiting <= 1'b0;
        end else begin
            waiting <= (st.sram_start | waiting) & ~data_rdy;
        end
    end

    // rows 1 to num-1 follow without gaps
    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
        end else begin
            running <= we & ~last;
        end
    end

    // row counter and buffer address counter
    always_ff @(posedge clk) begin
        if (rst) begin
            k_q    <= '0;
            addr_q <= '0;
        end else if (we) begin
            k_q    <= k_cur + 1'b1;
            addr_q <= addr_cur + 1'b1;
        end else if (st.sram_start) begin
            k_q    <= '0;
            addr_q <= st.cmd.sram_addr;
        end
    end

    // wraps past row 15 back to row 0
    assign row_sel = st.cmd.start_y + k_cur;

    // column window is 8 << len bits wide, starting at start_x bytes
    assign win_w  = 8'd8 << st.cmd.len;
    assign win_lo = {st.cmd.start_x, 3'b000};

    // width 128 shifts everything out, giving a full row
    assign win = ~(~row_data_t'(0) << win_w);

    assign wmask = win << win_lo;
    assign din   = rows[row_sel] & wmask;
    assign addr  = addr_cur;
    assign bank  = st.cmd.kind;

endmodule

// File: rtl/lsu_store_if.sv
`timescale 1ns/1ps

interface lsu_store_if;
    import lsu_pkg::*;

    // start pulses, one cycle after the accept edge
    logic       sram_start;
    logic       dram_start;
    store_cmd_t cmd;

    // finish strobes, high in the last cycle of a store
    logic       sram_done;
    logic       aw_done;

    modport ctrl (output sram_start, output dram_start, output cmd,
                  input sram_done, input aw_done);

    modport sram_eng (input sram_start, input cmd, output sram_done);

    modport dram_eng (input dram_start, input cmd, output aw_done);

endinterface

// File: rtl/lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
    input  logic                          clk,
    input  logic                          rst,

    // decode unit
    input  logic                          idu_lsu_vld,
    input  logic                          idu_lsu_st_iram,
    input  logic                          idu_lsu_st_wram,
    input  logic                          idu_lsu_st_oram,
    input  logic                          idu_lsu_st_dram,
    input  logic [30:0]                   idu_lsu_dram_addr,
    input  logic [7:0]                    idu_lsu_num,
    input  logic [2:0]                    idu_lsu_len,
    input  logic [2:0]                    idu_lsu_str,
    input  logic [3:0]                    idu_lsu_start_x,
    input  logic [3:0]                    idu_lsu_start_y,
    input  logic [11:0]                   idu_lsu_ld_st_addr,
    output logic                          lsu_idu_rdy,

    // matrix unit
    input  lsu_pkg::row_array_t           mxu_lsu_int8_rows,
    input  logic                          mxu_lsu_data_rdy,

    // buffer write port, bank decoded outside
    output logic                          lsu_sram_we,
    output lsu_pkg::store_kind_e          lsu_sram_bank,
    output lsu_pkg::sram_addr_t           lsu_sram_addr,
    output lsu_pkg::row_data_t            lsu_sram_wmask,
    output lsu_pkg::row_data_t            lsu_sram_din,

    // AXI write address channel
    output logic                          lsu_axi_awvld,
    output logic [lsu_pkg::AW_ADDR_W-1:0] lsu_axi_awaddr,
    output logic [7:0]                    lsu_axi_awlen,
    output logic [2:0]                    lsu_axi_awsize,
    output logic [2:0]                    lsu_axi_awstr,
    output logic [4:0]                    lsu_axi_awnum,
    input  logic                          axi_lsu_awrdy
);
    import lsu_pkg::*;

    store_cmd_t cmd_in;

    lsu_store_if st_if ();

    // kind is left at zero here, lsu_ctrl decodes it from the flags
    always_comb begin
        cmd_in           = '0;
        cmd_in.dram_addr = idu_lsu_dram_addr;
        cmd_in.num       = idu_lsu_num;
        cmd_in.len       = idu_lsu_len;
        cmd_in.str       = idu_lsu_str;
        cmd_in.start_x   = idu_lsu_start_x;
        cmd_in.start_y   = idu_lsu_start_y;
        cmd_in.sram_addr = idu_lsu_ld_st_addr[11:4];
    end

    lsu_ctrl i_ctrl (
        .clk       (clk),
        .rst       (rst),
        .instr_vld (idu_lsu_vld),
        .st_iram   (idu_lsu_st_iram),
        .st_wram   (idu_lsu_st_wram),
        .st_oram   (idu_lsu_st_oram),
        .st_dram   (idu_lsu_st_dram),
        .cmd_in    (cmd_in),
        .rdy       (lsu_idu_rdy),
        .st        (st_if.ctrl)
    );

    lsu_row_store i_row_store (
        .clk      (clk),
        .rst      (rst),
        .rows     (mxu_lsu_int8_rows),
        .data_rdy (mxu_lsu_data_rdy),
        .st       (st_if.sram_eng),
        .we       (lsu_sram_we),
        .bank     (lsu_sram_bank),
        .addr     (lsu_sram_addr),
        .wmask    (lsu_sram_wmask),
        .din      (lsu_sram_din)
    );

    lsu_aw_issue i_aw_issue (
        .clk    (clk),
        .rst    (rst),
        .awrdy  (axi_lsu_awrdy),
        .st     (st_if.dram_eng),
        .awvld  (lsu_axi_awvld),
        .awaddr (lsu_axi_awaddr),
        .awlen  (lsu_axi_awlen),
        .awsize (lsu_axi_awsize),
        .awstr  (lsu_axi_awstr),
        .awnum  (lsu_axi_awnum)
    );

endmodule

// File: sim.f
rtl/lsu_pkg.sv
rtl/lsu_store_if.sv
rtl/lsu_ctrl.sv
rtl/lsu_row_store.sv
rtl/lsu_aw_issue.sv
rtl/lsu_top.sv
+incdir+verif
verif/lsu_tb.sv

// File: verif/lsu_patterns.txt
# iram wram oram dram dram_addr num len str start_x start_y ld_st_addr b2b, then expected
# kind first_addr wmask awaddr awnum, all hex, unused expected fields are 0
1 0 0 0 00000000 04 0 0 0 0 120 0 0 12 000000000000000000000000000000ff 000 00
0 1 0 0 00000000 03 1 0 2 5 3f0 0 1 3f 000000000000000000000000ffff0000 000 00
0 0 1 0 00000000 10 4 0 0 a ff0 0 2 ff ffffffffffffffffffffffffffffffff 000 00
0 0 0 1 12345670 08 2 3 0 0 000 0 3 00 00000000000000000000000000000000 167 04
0 0 0 0 00000000 04 0 0 0 0 000 0 0 00 00000000000000000000000000000000 000 00
1 0 0 1 0000a000 02 2 0 4 f 085 0 0 08 0000000000000000ffffffff00000000 000 00
0 1 1 1 00000000 05 3 0 8 3 a00 1 1 a0 ffffffffffffffff0000000000000000 000 00
0 0 1 1 00000000 01 0 0 f 7 7ff 1 2 7f ff000000000000000000000000000000 000 00
0 0 0 1 7fffffff 10 0 7 0 0 000 1 3 00 00000000000000000000000000000000 3ff 10
0 0 0 1 00004010 01 4 0 0 0 000 1 3 00 00000000000000000000000000000000 001 01
1 0 0 0 00000000 10 4 0 3 0 000 1 0 00 ffffffffffffffffffffffffff000000 000 00
0 1 0 0 00000000 07 1 0 e 9 555 0 1 55 ffff0000000000000000000000000000 000 00
0 0 1 0 00000000 02 2 0 d 2 010 0 2 01 ffffff00000000000000000000000000 000 00
0 0 0 1 0000abcd 20 1 5 0 0 000 0 3 00 00000000000000000000000000000000 2bc 08
1 0 0 0 00000000 01 3 0 1 0 fff 0 0 ff 00000000000000ffffffffffffffff00 000 00
0 1 0 0 00000000 08 0 0 5 c 8c0 1 1 8c 00000000000000000000ff0000000000 000 00
0 0 0 0 00000000 02 1 0 0 0 000 0 0 00 00000000000000000000000000000000 000 00
0 1 1 0 00000000 03 4 0 0 e 2a0 0 1 2a ffffffffffffffffffffffffffffffff 000 00
0 0 1 1 00000000 04 1 0 6 1 0c0 0 2 0c 0000000000000000ffff000000000000 000 00
0 0 0 1 000003f0 04 3 1 0 0 000 1 3 00 00000000000000000000000000000000 03f 02

// File: verif/lsu_tb_checks.svh
`ifndef LSU_TB_CHECKS_SVH
`define LSU_TB_CHECKS_SVH

// compare tasks, one per result type of the DUT

task automatic check_kind(input string name, input store_kind_e exp, input store_kind_e act);
    if (exp !== act) begin
        $display("ERROR at %0t ns: %s expected %0h, actual %0h", $time, name, exp, act);
        abort_run();
    end
endtask

task automatic check_addr(input string name, input sram_addr_t exp, input sram_addr_t act);
    if (exp !== act) begin
        $display("ERROR at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
        abort_run();
    end
endtask

// write mask and write data share the row type
task automatic check_row(input string name, input row_data_t exp, input row_data_t act);
    if (exp !== act) begin
        $display("ERROR at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
        abort_run();
    end
endtask

task automatic check_aw_addr(input string name, input logic [AW_ADDR_W-1:0] exp,
                             input logic [AW_ADDR_W-1:0] act);
    if (exp !== act) begin
        $display("ERROR at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
        abort_run();
    end
endtask

// narrower AW fields come in zero extended
task automatic check_aw_field(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act) begin
        $display("ERROR at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
        abort_run();
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
        $display("ERROR at %0t ns: %s expected %b, actual %b", $time, name, exp, act);
        abort_run();
    end
endtask

`endif

// File: verif/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;
    import lsu_pkg::*;

    typedef struct {
        logic                 iram;
        logic                 wram;
        logic                 oram;
        logic                 dram;
        logic [30:0]          dram_addr;
        logic [7:0]           num;
        logic [2:0]           len;
        logic [2:0]           str;
        logic [3:0]           start_x;
        logic [3:0]           start_y;
        logic [11:0]          ld_st_addr;
        logic                 btb;
        store_kind_e          kind;
        sram_addr_t           first;
        row_data_t            mask;
        logic [AW_ADDR_W-1:0] awaddr;
        logic [4:0]           awnum;
    } pattern_t;

    logic                 clk;
    logic                 rst;
    logic                 idu_lsu_vld;
    logic                 idu_lsu_st_iram;
    logic                 idu_lsu_st_wram;
    logic                 idu_lsu_st_oram;
    logic                 idu_lsu_st_dram;
    logic [30:0]          idu_lsu_dram_addr;
    logic [7:0]           idu_lsu_num;
    logic [2:0]           idu_lsu_len;
    logic [2:0]           idu_lsu_str;
    logic [3:0]           idu_lsu_start_x;
    logic [3:0]           idu_lsu_start_y;
    logic [11:0]          idu_lsu_ld_st_addr;
    logic                 lsu_idu_rdy;
    row_array_t           mxu_lsu_int8_rows;
    logic                 mxu_lsu_data_rdy;
    logic                 lsu_sram_we;
    store_kind_e          lsu_sram_bank;
    sram_addr_t           lsu_sram_addr;
    row_data_t            lsu_sram_wmask;
    row_data_t            lsu_sram_din;
    logic                 lsu_axi_awvld;
    logic [AW_ADDR_W-1:0] lsu_axi_awaddr;
    logic [7:0]           lsu_axi_awlen;
    logic [2:0]           lsu_axi_awsize;
    logic [2:0]           lsu_axi_awstr;
    logic [4:0]           lsu_axi_awnum;
    logic                 axi_lsu_awrdy;

    pattern_t pats[$];
    bit       loaded;

    lsu_top i_dut (.*);

    always #50 clk = ~clk;

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic protocol_error(input string what);
        $display("at %0t ns: %s", $time, what);
        abort_run();
    endtask

    `include "lsu_tb_checks.svh"

    task automatic load_patterns();
        int           fd;
        int           n;
        string        line;
        pattern_t     p;
        logic [127:0] f_ir, f_wr, f_or, f_dr, daddr, num, len, str, sx, sy;
        logic [127:0] ld, b2b, kind, first, mask, awa, awn;
        fd = $fopen("verif/lsu_patterns.txt", "r");
        if (fd == 0) begin
            protocol_error("could not open verif/lsu_patterns.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // skip comments and blank lines
            if (line.len() < 2 || line.getc(0) == "#") continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f_ir, f_wr, f_or, f_dr, daddr, num, len, str, sx, sy,
                        ld, b2b, kind, first, mask, awa, awn);
            if (n != 17) begin
                protocol_error("malformed line in the pattern file");
            end
            p.iram       = f_ir[0];
            p.wram       = f_wr[0];
            p.oram       = f_or[0];
            p.dram       = f_dr[0];
            p.dram_addr  = daddr[30:0];
            p.num        = num[7:0];
            p.len        = len[2:0];
            p.str        = str[2:0];
            p.start_x    = sx[3:0];
            p.start_y    = sy[3:0];
            p.ld_st_addr = ld[11:0];
            p.btb        = b2b[0];
            p.kind       = store_kind_e'(kind[1:0]);
            p.first      = first[7:0];
            p.mask       = mask;
            p.awaddr     = awa[AW_ADDR_W-1:0];
            p.awnum      = awn[4:0];
            pats.push_back(p);
        end
        $fclose(fd);
        if (pats.size() == 0) begin
            protocol_error("the pattern file holds no patterns");
        end
    endtask

    task automatic present(input pattern_t p);
        idu_lsu_vld        = 1'b1;
        idu_lsu_st_iram    = p.iram;
        idu_lsu_st_wram    = p.wram;
        idu_lsu_st_oram    = p.oram;
        idu_lsu_st_dram    = p.dram;
        idu_lsu_dram_addr  = p.dram_addr;
        idu_lsu_num        = p.num;
        idu_lsu_len        = p.len;
        idu_lsu_str        = p.str;
        idu_lsu_start_x    = p.start_x;
        idu_lsu_start_y    = p.start_y;
        idu_lsu_ld_st_addr = p.ld_st_addr;
    endtask

    task automatic fill_rows();
        for (int r = 0; r < ROW_NUM; r++) begin
            for (int w = 0; w < ROW_BITS / 32; w++) begin
                mxu_lsu_int8_rows[r][w*32 +: 32] = $urandom();
            end
        end
    endtask

    task automatic next_slot();
        @(posedge clk);
        #10;
    endtask

    // starts in the drive slot of the cycle after the accept edge
    task automatic run_sram(input pattern_t p);
        int         delay;
        int         cyc;
        int         k;
        bit         exp_we;
        row_idx_t   ridx;
        sram_addr_t exp_addr;
        delay = $urandom_range(5, 0);
        cyc   = 0;
        k     = 0;
        while (k < int'(p.num)) begin
            mxu_lsu_data_rdy = (cyc >= delay);
            @(negedge clk);
            exp_we = (cyc >= delay);
            check_bit("lsu_sram_we", exp_we, lsu_sram_we);
            if (lsu_axi_awvld) protocol_error("AW request raised during an SRAM store");
            if (exp_we) begin
                ridx     = p.start_y + k[3:0];
                exp_addr = p.first + k[7:0];
                check_kind("lsu_sram_bank", p.kind, lsu_sram_bank);
                check_addr("lsu_sram_addr", exp_addr, lsu_sram_addr);
                check_row("lsu_sram_wmask", p.mask, lsu_sram_wmask);
                check_row("lsu_sram_din", mxu_lsu_int8_rows[ridx] & p.mask, lsu_sram_din);
                k++;
            end
            if (exp_we && k == int'(p.num)) begin
                check_bit("lsu_idu_rdy", 1'b1, lsu_idu_rdy);
            end else if (lsu_idu_rdy) begin
                protocol_error("rdy high while an SRAM store is busy");
            end
            next_slot();
            cyc++;
        end
        mxu_lsu_data_rdy = 1'b0;
    endtask

    task automatic run_dram(input pattern_t p);
        int stall;
        stall = $urandom_range(3, 0);
        for (int cyc = 0; cyc <= stall; cyc++) begin
            axi_lsu_awrdy = (cyc == stall);
            @(negedge clk);
            check_bit("lsu_axi_awvld", 1'b1, lsu_axi_awvld);
            check_aw_addr("lsu_axi_awaddr", p.awaddr, lsu_axi_awaddr);
            check_aw_field("lsu_axi_awlen", p.num, lsu_axi_awlen);
            check_aw_field("lsu_axi_awsize", {5'b0, p.len}, {5'b0, lsu_axi_awsize});
            check_aw_field("lsu_axi_awstr", {5'b0, p.str}, {5'b0, lsu_axi_awstr});
            check_aw_field("lsu_axi_awnum", {3'b0, p.awnum}, {3'b0, lsu_axi_awnum});
            if (lsu_sram_we) protocol_error("SRAM write during a DRAM store");
            if (cyc == stall) begin
                check_bit("lsu_idu_rdy", 1'b1, lsu_idu_rdy);
            end else if (lsu_idu_rdy) begin
                protocol_error("rdy high while a DRAM store is busy");
            end
            next_slot();
        end
        axi_lsu_awrdy = 1'b0;
    endtask

    // early is set when this line was already accepted back to back
    task automatic run_line(input int i, inout bit early);
        pattern_t p;
        bit       is_store;
        bit       chain;
        p        = pats[i];
        is_store = p.iram | p.wram | p.oram | p.dram;
        chain    = is_store && (i + 1 < pats.size()) && pats[i+1].btb;
        if (!is_store || !early) begin
            present(p);
            repeat (is_store ? 1 : 3) begin
                @(negedge clk);
                check_bit("lsu_idu_rdy", 1'b1, lsu_idu_rdy);
                check_bit("lsu_sram_we", 1'b0, lsu_sram_we);
                check_bit("lsu_axi_awvld", 1'b0, lsu_axi_awvld);
                next_slot();
            end
        end
        idu_lsu_vld = 1'b0;
        if (is_store) begin
            fill_rows();
            // next line waits on the inputs while this store runs
            if (chain) present(pats[i+1]);
            if (p.kind == STORE_DRAM) run_dram(p);
            else run_sram(p);
            idu_lsu_vld = 1'b0;
        end
        early = chain;
    endtask

    initial begin
        wait (loaded);
        repeat (pats.size() * 40 + 20) @(posedge clk);
        $display("timeout: the DUT stopped making progress");
        abort_run();
    end

    initial begin
        bit early;
        void'($urandom(88946));
        clk                = 1'b0;
        rst                = 1'b1;
        idu_lsu_vld        = 1'b0;
        idu_lsu_st_iram    = 1'b0;
        idu_lsu_st_wram    = 1'b0;
        idu_lsu_st_oram    = 1'b0;
        idu_lsu_st_dram    = 1'b0;
        idu_lsu_dram_addr  = '0;
        idu_lsu_num        = '0;
        idu_lsu_len        = '0;
        idu_lsu_str        = '0;
        idu_lsu_start_x    = '0;
        idu_lsu_start_y    = '0;
        idu_lsu_ld_st_addr = '0;
        mxu_lsu_int8_rows  = '0;
        mxu_lsu_data_rdy   = 1'b0;
        axi_lsu_awrdy      = 1'b0;
        early              = 1'b0;
        load_patterns();
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        #10;
        rst = 1'b0;
        @(negedge clk);
        check_bit("lsu_idu_rdy", 1'b1, lsu_idu_rdy);
        check_bit("lsu_sram_we", 1'b0, lsu_sram_we);
        check_bit("lsu_axi_awvld", 1'b0, lsu_axi_awvld);
        next_slot();
        for (int i = 0; i < pats.size(); i++) begin
            run_line(i, early);
        end
        $display("test passed");
        $finish;
    end

endmodule
